// ==== logic/accel_config.svh ====
`ifndef ACCEL_CONFIG_SVH
`define ACCEL_CONFIG_SVH

// ======================================================================
// accelerator sizing
// ======================================================================

// input word and coefficient width
`define ACCEL_WORD_W 16

// result width, products wrap modulo 2^32
`define ACCEL_ACC_W 32

// buffer address width
`define ACCEL_ADDR_W 4

// words per block, fills the buffer exactly
`define ACCEL_BLOCK_LEN 16

`endif

// ==== logic/accel_pkg.sv ====
`default_nettype none

`include "accel_config.svh"

package accel_pkg;

    // input words and coefficients
    typedef logic [`ACCEL_WORD_W-1:0] word_t;

    // multiply-add results
    typedef logic [`ACCEL_ACC_W-1:0] acc_t;

    // input and result buffer addresses
    typedef logic [`ACCEL_ADDR_W-1:0] addr_t;

    // core sequencer
    typedef enum logic [1:0] {
        idle,
        run,
        drain
    } core_state_t;

endpackage

`default_nettype wire

// ==== logic/agu.sv ====
`timescale 1ns/1ns
`default_nettype none

module agu #(
    parameter int W = 8
) (
    input  wire          clk,
    input  wire          rst,
    input  wire          en,
    input  wire          start,
    input  wire  [W-1:0] ini,
    input  wire  [W-1:0] fin,
    output logic [W-1:0] data,
    output logic         last
);

    // set between start and the final step
    logic running;

    // ======================================================================
    // counter
    // ======================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            data    <= '0;
        end else if (en) begin
            if (start) begin
                // restart from ini
                running <= 1'b1;
                data    <= ini;
            end else if (running) begin
                if (data == fin) begin
                    // stop on fin, data parks there
                    running <= 1'b0;
                end else begin
                    data <= data + 1'b1;
                end
            end
        end
    end

    // final step, only counts when enabled
    assign last = en & running & (data == fin);

endmodule

`default_nettype wire

// ==== logic/load_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "accel_config.svh"

module load_ctrl (
    input  wire                clk,
    input  wire                rst,
    input  wire                src_valid,
    output logic               wr_en,
    output accel_pkg::addr_t   wr_addr,
    output logic               loaded
);

    // first word goes to address 0 directly, agu covers 1 .. len-1
    localparam accel_pkg::addr_t first_ini = accel_pkg::addr_t'(1);
    localparam accel_pkg::addr_t last_addr = accel_pkg::addr_t'(`ACCEL_BLOCK_LEN - 1);

    // block in progress
    logic             in_block;
    logic             agu_start;
    logic             agu_last;
    accel_pkg::addr_t agu_addr;

    // a strobe outside a block opens one
    assign agu_start = src_valid & ~in_block;

    agu #(.W(`ACCEL_ADDR_W)) agu_load_inst (
        .clk   (clk),
        .rst   (rst),
        .en    (src_valid),
        .start (agu_start),
        .ini   (first_ini),
        .fin   (last_addr),
        .data  (agu_addr),
        .last  (agu_last)
    );

    // every strobe is one write
    assign wr_en   = src_valid;
    assign wr_addr = in_block ? agu_addr : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_block <= 1'b0;
            loaded   <= 1'b0;
        end else begin
            // one cycle pulse after the last word
            loaded <= agu_last;
            if (agu_last) begin
                in_block <= 1'b0;
            end else if (agu_start) begin
                in_block <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/mac_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "accel_config.svh"

module mac_core (
    input  wire                clk,
    input  wire                rst,
    input  wire                loaded,
    input  accel_pkg::word_t   coef_a,
    input  accel_pkg::word_t   coef_b,
    output accel_pkg::addr_t   rd_addr,
    input  accel_pkg::word_t   rd_data,
    output logic               res_we,
    output accel_pkg::addr_t   res_addr,
    output accel_pkg::acc_t    res_data,
    output logic               done
);

    localparam accel_pkg::addr_t last_addr = accel_pkg::addr_t'(`ACCEL_BLOCK_LEN - 1);
    localparam int pad_w = `ACCEL_ACC_W - `ACCEL_WORD_W;

    accel_pkg::core_state_t state;
    logic                   agu_start;
    logic                   agu_last;
    accel_pkg::acc_t        mac_val;

    // ======================================================================
    // sequencer
    // ======================================================================

    // only accept a block from idle
    assign agu_start = loaded & (state == accel_pkg::idle);

    agu #(.W(`ACCEL_ADDR_W)) agu_core_inst (
        .clk   (clk),
        .rst   (rst),
        .en    (1'b1),
        .start (agu_start),
        .ini   ('0),
        .fin   (last_addr),
        .data  (rd_addr),
        .last  (agu_last)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= accel_pkg::idle;
        end else begin
            case (state)
                accel_pkg::idle:  if (loaded) state <= accel_pkg::run;
                accel_pkg::run:   if (agu_last) state <= accel_pkg::drain;
                accel_pkg::drain: state <= accel_pkg::idle;
                default:          state <= accel_pkg::idle;
            endcase
        end
    end

    // ======================================================================
    // multiply-add stage
    // ======================================================================

    // zero extended, sum wraps at acc width
    assign mac_val = {{pad_w{1'b0}}, coef_a} * {{pad_w{1'b0}}, rd_data}
                   + {{pad_w{1'b0}}, coef_b};

    // result and address one cycle behind the read
    always_ff @(posedge clk) begin
        res_data <= mac_val;
        res_addr <= rd_addr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_we <= 1'b0;
            done   <= 1'b0;
        end else begin
            res_we <= (state == accel_pkg::run);
            // last write lands during drain
            done   <= (state == accel_pkg::drain);
        end
    end

endmodule

`default_nettype wire

// ==== logic/result_buf.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "accel_config.svh"

module result_buf (
    input  wire                clk,
    input  wire                we,
    input  accel_pkg::addr_t   waddr,
    input  accel_pkg::acc_t    wdata,
    input  wire                re,
    input  wire                en,
    input  accel_pkg::addr_t   raddr,
    output accel_pkg::acc_t    rdata
);

    // one block of results
    accel_pkg::acc_t mem [`ACCEL_BLOCK_LEN];

    // write port, core side
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // ======================================================================
    // read port, stream side
    // ======================================================================

    // loads with stream_v under dst_ready
    // holds through stalls so data stays with dst_valid
    always_ff @(posedge clk) begin
        if (en && re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

// ==== logic/stream_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "accel_config.svh"

module stream_ctrl (
    input  wire                clk,
    input  wire                rst,
    input  wire                done,
    input  wire                dst_ready,
    output logic               dst_valid,
    output logic               dst_last,
    output logic               stream_v,
    output accel_pkg::addr_t   stream_a
);

    localparam accel_pkg::addr_t last_addr = accel_pkg::addr_t'(`ACCEL_BLOCK_LEN - 1);

    logic done_n;
    logic done_nn;
    logic done_keep;
    logic stream_ok;
    logic stream_ok_r;
    logic stream_start;
    logic stream_active;
    logic last_stream;

    // ======================================================================
    // done pickup
    // ======================================================================

    // two stage delay on done
    always_ff @(posedge clk) begin
        if (rst) begin
            done_n  <= 1'b0;
            done_nn <= 1'b0;
        end else begin
            done_n  <= done;
            done_nn <= done_n;
        end
    end

    // remember done until the sink is ready
    always_ff @(posedge clk) begin
        if (rst) begin
            done_keep <= 1'b0;
        end else if (stream_ok) begin
            done_keep <= 1'b0;
        end else if (done_nn) begin
            done_keep <= 1'b1;
        end
    end

    // go when done is seen and the sink is enabled
    assign stream_ok = (done_nn | done_keep) & dst_ready;

    // registered ok, frozen by stalls
    always_ff @(posedge clk) begin
        if (rst) begin
            stream_ok_r <= 1'b0;
        end else if (dst_ready) begin
            stream_ok_r <= stream_ok;
        end
    end

    assign stream_start = stream_ok_r & dst_ready;

    // ======================================================================
    // read address walk
    // ======================================================================

    agu #(.W(`ACCEL_ADDR_W)) agu_stream_inst (
        .clk   (clk),
        .rst   (rst),
        .en    (dst_ready),
        .start (stream_start),
        .ini   ('0),
        .fin   (last_addr),
        .data  (stream_a),
        .last  (last_stream)
    );

    // active while the agu runs
    // opens with its start so address 0 is the first read
    always_ff @(posedge clk) begin
        if (rst) begin
            stream_active <= 1'b0;
        end else if (last_stream) begin
            stream_active <= 1'b0;
        end else if (stream_start) begin
            stream_active <= 1'b1;
        end
    end

    // read strobe toward result_buf
    assign stream_v = stream_active & dst_ready;

    // ======================================================================
    // sink side flags
    // ======================================================================

    // both follow the read register, one cycle behind stream_v
    always_ff @(posedge clk) begin
        if (rst) begin
            dst_valid <= 1'b0;
            dst_last  <= 1'b0;
        end else if (dst_ready) begin
            dst_valid <= stream_active;
            dst_last  <= stream_active & last_stream;
        end
    end

endmodule

`default_nettype wire

// ==== logic/accel_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "accel_config.svh"

module accel_top (
    input  wire                clk,
    input  wire                rst,
    input  wire                src_valid,
    input  accel_pkg::word_t   src_data,
    input  accel_pkg::word_t   coef_a,
    input  accel_pkg::word_t   coef_b,
    input  wire                dst_ready,
    output logic               dst_valid,
    output accel_pkg::acc_t    dst_data,
    output logic               dst_last,
    output logic               busy
);

    // loader to input buffer
    logic             wr_en;
    accel_pkg::addr_t wr_addr;
    logic             loaded;

    // core side
    accel_pkg::addr_t rd_addr;
    accel_pkg::word_t rd_data;
    logic             res_we;
    accel_pkg::addr_t res_addr;
    accel_pkg::acc_t  res_data;
    logic             done;

    // stream side
    logic             stream_v;
    accel_pkg::addr_t stream_a;
    logic             beat_last;

    // input buffer, async read into the core
    accel_pkg::word_t in_buf [`ACCEL_BLOCK_LEN];

    // ======================================================================
    // load path
    // ======================================================================

    load_ctrl load_ctrl_inst (
        .clk       (clk),
        .rst       (rst),
        .src_valid (src_valid),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .loaded    (loaded)
    );

    always_ff @(posedge clk) begin
        if (wr_en) begin
            in_buf[wr_addr] <= src_data;
        end
    end

    assign rd_data = in_buf[rd_addr];

    // ======================================================================
    // compute and stream
    // ======================================================================

    mac_core mac_core_inst (
        .clk      (clk),
        .rst      (rst),
        .loaded   (loaded),
        .coef_a   (coef_a),
        .coef_b   (coef_b),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .res_we   (res_we),
        .res_addr (res_addr),
        .res_data (res_data),
        .done     (done)
    );

    result_buf result_buf_inst (
        .clk   (clk),
        .we    (res_we),
        .waddr (res_addr),
        .wdata (res_data),
        .re    (stream_v),
        .en    (dst_ready),
        .raddr (stream_a),
        .rdata (dst_data)
    );

    stream_ctrl stream_ctrl_inst (
        .clk       (clk),
        .rst       (rst),
        .done      (done),
        .dst_ready (dst_ready),
        .dst_valid (dst_valid),
        .dst_last  (dst_last),
        .stream_v  (stream_v),
        .stream_a  (stream_a)
    );

    // final beat of a block taken by the sink
    assign beat_last = dst_valid & dst_ready & dst_last;

    // busy from first strobe to the last accepted beat
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (src_valid) begin
            busy <= 1'b1;
        end else if (beat_last) begin
            busy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_accel.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "accel_config.svh"

module tb_accel;

    localparam int block_len = `ACCEL_BLOCK_LEN;
    localparam int num_rows  = 7;
    // doubled sum of load, core and stream, and stalled beat cycles
    localparam int cycle_limit = num_rows * (block_len + 40 + block_len * 4) * 2;

    // one test row with coefficients, data ramp, stall mode and reset point
    typedef struct {
        accel_pkg::word_t a;
        accel_pkg::word_t b;
        accel_pkg::word_t base;
        accel_pkg::word_t step;
        bit               stall;
        int               rst_after;
    } row_t;

    logic             clk;
    logic             rst;
    logic             src_valid;
    accel_pkg::word_t src_data;
    accel_pkg::word_t coef_a;
    accel_pkg::word_t coef_b;
    logic             dst_ready;
    logic             dst_valid;
    accel_pkg::acc_t  dst_data;
    logic             dst_last;
    logic             busy;

    row_t            rows [num_rows];
    accel_pkg::acc_t exp_q [$];
    accel_pkg::acc_t want;
    logic            want_last;
    bit              stall_mode;
    int              errors;
    int              beats_seen;
    int              lasts_seen;
    int              tests_failed;
    int              cycles;
    int              r;

    accel_top accel_top_inst (
        .clk       (clk),
        .rst       (rst),
        .src_valid (src_valid),
        .src_data  (src_data),
        .coef_a    (coef_a),
        .coef_b    (coef_b),
        .dst_ready (dst_ready),
        .dst_valid (dst_valid),
        .dst_data  (dst_data),
        .dst_last  (dst_last),
        .busy      (busy)
    );

    always #2 clk = ~clk;

    // ======================================================================
    // reference model and helpers
    // ======================================================================

    // y = a*x + b kept modulo 2^32
    function automatic accel_pkg::acc_t mac_ref(input accel_pkg::word_t a,
                                                input accel_pkg::word_t x,
                                                input accel_pkg::word_t b);
        logic [63:0] full;
        full = 64'(a) * 64'(x) + 64'(b);
        return full[31:0];
    endfunction

    // input ramp wrapping at 16 bits
    function automatic accel_pkg::word_t word_at(input accel_pkg::word_t base,
                                                 input accel_pkg::word_t step,
                                                 input int i);
        return base + step * accel_pkg::word_t'(i);
    endfunction

    // wait for the falling edge and pick a new dst_ready level
    task automatic next_cycle();
        logic [31:0] rnd;
        @(negedge clk);
        rnd = $urandom;
        dst_ready = stall_mode ? rnd[0] : 1'b1;
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %0h expected %0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic fill_table();
        //          a         b         base      step      stall rst_after
        rows[0] = '{16'h0003, 16'h0005, 16'h0010, 16'h0003, 1'b0, 0};
        rows[1] = '{16'hffff, 16'hffff, 16'hfff0, 16'h0101, 1'b1, 0};
        rows[2] = '{16'h1234, 16'h00ff, 16'h0100, 16'h0007, 1'b0, 0};
        rows[3] = '{16'h8001, 16'h4000, 16'h7ff8, 16'h0011, 1'b1, 0};
        // reset lands while the final beat with dst_last waits
        rows[4] = '{16'h0007, 16'h0003, 16'h0055, 16'h0005, 1'b1, 15};
        rows[5] = '{16'h00a5, 16'h5a5a, 16'h0200, 16'h0013, 1'b1, 0};
        rows[6] = '{16'h0000, 16'h1111, 16'habcd, 16'h0001, 1'b0, 0};
    endtask

    // ======================================================================
    // beat checker
    // ======================================================================

    always @(posedge clk) begin
        if (!rst && dst_valid && dst_ready) begin
            if (exp_q.size() == 0) begin
                $display("unexpected beat accepted with no result pending");
                errors++;
            end else begin
                // last beat is the final queued result
                want_last = (exp_q.size() == 1);
                want = exp_q.pop_front();
                if (dst_data !== want) begin
                    $display("MISMATCH dst_data beat %0d: got %08h expected %08h",
                             beats_seen, dst_data, want);
                    errors++;
                end
                if (dst_last !== want_last) begin
                    $display("MISMATCH dst_last beat %0d: got %0h expected %0h",
                             beats_seen, dst_last, want_last);
                    errors++;
                end
                if (dst_last) lasts_seen++;
                beats_seen++;
            end
        end
    end

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    // ======================================================================
    // one block per table row
    // ======================================================================

    task automatic run_block(input int idx);
        row_t row;
        int   errs_before;
        row = rows[idx];
        errs_before = errors;
        beats_seen = 0;
        lasts_seen = 0;
        stall_mode = row.stall;
        // idle gap with the engine free
        repeat (3) begin
            next_cycle();
            check_bit("busy", busy, 1'b0);
        end
        coef_a = row.a;
        coef_b = row.b;
        for (int i = 0; i < block_len; i++) begin
            exp_q.push_back(mac_ref(row.a, word_at(row.base, row.step, i), row.b));
        end
        // 16 back to back strobes
        for (int i = 0; i < block_len; i++) begin
            src_valid = 1'b1;
            src_data = word_at(row.base, row.step, i);
            next_cycle();
            check_bit("busy", busy, 1'b1);
        end
        src_valid = 1'b0;
        if (row.rst_after != 0) begin
            while (beats_seen < row.rst_after) begin
                next_cycle();
            end
            rst = 1'b1;
            repeat (2) next_cycle();
            rst = 1'b0;
            check_bit("dst_valid", dst_valid, 1'b0);
            check_bit("dst_last", dst_last, 1'b0);
            check_bit("busy", busy, 1'b0);
            exp_q.delete();
        end else begin
            // busy holds until the last beat is taken
            while (exp_q.size() != 0) begin
                check_bit("busy", busy, 1'b1);
                next_cycle();
            end
            check_bit("busy", busy, 1'b0);
            if (lasts_seen != 1) begin
                $display("block %0d saw dst_last %0d times instead of once", idx, lasts_seen);
                errors++;
            end
        end
        if (errors != errs_before) tests_failed++;
        $display("test %0d: %s, %0d beats, %0d errors", idx,
                 (errors == errs_before) ? "ok" : "bad", beats_seen, errors - errs_before);
    endtask

    initial begin
        void'($urandom(32'ha6e63eb1));
        clk = 1'b0;
        rst = 1'b1;
        src_valid = 1'b0;
        src_data = '0;
        coef_a = '0;
        coef_b = '0;
        dst_ready = 1'b1;
        stall_mode = 1'b0;
        fill_table();
        repeat (2) next_cycle();
        rst = 1'b0;
        for (r = 0; r < num_rows; r++) begin
            run_block(r);
        end
        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 num_rows, num_rows - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+logic
logic/accel_pkg.sv
logic/agu.sv
logic/load_ctrl.sv
logic/mac_core.sv
logic/result_buf.sv
logic/stream_ctrl.sv
logic/accel_top.sv
tb/tb_accel.sv

// ==== Makefile ====
# Verilator build and run for the block accelerator

VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ns -j 0
TOP       = tb_accel
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
